// File: hdl/gfx_pkg.sv
// shared constants for the graphics core: frame geometry, host address map,
// copper opcodes and reset colours. referenced by scoped name only
package gfx_pkg;

	// frame geometry, kept tiny for short sims
	localparam int H_TOTAL  = 32; // clocks per line
	localparam int V_TOTAL  = 20; // lines per frame
	localparam int H_ACTIVE = 24;
	localparam int V_ACTIVE = 16;
	localparam int COORD_W  = 10;

	// word sizes
	localparam int ADDR_W  = 12; // host bus address
	localparam int LIST_AW = 9;  // copper list, 512 words
	localparam int INS_W   = 16;
	localparam int COLOR_W = 12; // 4:4:4 rgb

	// host address map
	localparam logic [ADDR_W-1:0] ADDR_PAL_BASE = 12'hd00; // 16 entries up to 0xd0f
	localparam logic [ADDR_W-1:0] ADDR_XPAN     = 12'hd20;
	localparam logic [ADDR_W-1:0] ADDR_YFLIP    = 12'hd21;
	localparam logic [ADDR_W-1:0] ADDR_BG       = 12'hd22;
	// list window 0x400..0x5ff, compared on address bits 11:9
	localparam logic [ADDR_W-LIST_AW-1:0] ADDR_LIST_SEL = 3'b010;

	// copper opcodes, instruction bits 15:12
	localparam logic [3:0] OP_NOP    = 4'h0;
	localparam logic [3:0] OP_WAIT_Y = 4'h1; // operand = line
	localparam logic [3:0] OP_WRITE  = 4'h2; // operand = reg addr, next word = data
	localparam logic [3:0] OP_JUMP   = 4'h3; // operand = list addr
	localparam logic [3:0] OP_SET_BG = 4'h7; // operand = colour
	localparam logic [3:0] OP_HALT   = 4'hf;

	// reset colours
	localparam logic [COLOR_W-1:0] BG_RESET = 12'hf00;

endpackage

// File: hdl/bram.sv
// simple dual port block RAM, one write port and one registered read port.
// read data appears the clock after the read address
`timescale 1ns/1ns

module bram #(
	parameter int BITS         = 16,
	parameter int ADDRESS_BITS = 9
) (
	input  logic                    CLK,

	input  logic [ADDRESS_BITS-1:0] rd_addr,
	output logic [BITS-1:0]         rd_data,

	input  logic [ADDRESS_BITS-1:0] wr_addr,
	input  logic [BITS-1:0]         wr_data,
	input  logic                    wr
);

	logic [BITS-1:0] mem [2**ADDRESS_BITS];

	// write port
	always_ff @(posedge CLK) begin
		if (wr)
			mem[wr_addr] <= wr_data;
	end

	// read port, old data on a same-address collision
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: hdl/video_timing.sv
// raster counters for the display. gives the current pixel position plus
// end-of-line and start-of-frame strobes, valid from the first clock after reset
`timescale 1ns/1ns

module video_timing (
	input  logic                        CLK,
	input  logic                        RSTb,

	output logic [gfx_pkg::COORD_W-1:0] display_x,
	output logic [gfx_pkg::COORD_W-1:0] display_y,
	output logic                        H_tick,
	output logic                        V_tick
);

	logic last_x;
	logic last_y;

	assign last_x = (display_x == gfx_pkg::H_TOTAL - 1);
	assign last_y = (display_y == gfx_pkg::V_TOTAL - 1);

	// pixel counter
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			display_x <= '0;
		end else if (last_x) begin
			display_x <= '0;
		end else begin
			display_x <= display_x + 1'b1;
		end
	end

	// line counter, steps at end of line
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			display_y <= '0;
		end else if (last_x) begin
			if (last_y)
				display_y <= '0; // wrap to new frame
			else
				display_y <= display_y + 1'b1;
		end
	end

	assign H_tick = last_x;                                   // last clock of line
	assign V_tick = (display_x == '0) && (display_y == '0);   // frame origin

	// counters must never leave the frame
	a_coord_range: assert property (@(posedge CLK) disable iff (!RSTb)
		(display_x < gfx_pkg::H_TOTAL) && (display_y < gfx_pkg::V_TOTAL));

endmodule

// File: hdl/copper.sv
// copper: display list co-processor. runs a list from its own RAM each frame,
// drives the background colour, palette writes and the pan / flip of coordinates
`timescale 1ns/1ns

module copper (
	input  logic                        CLK,
	input  logic                        RSTb,

	input  logic [gfx_pkg::ADDR_W-1:0]  ADDRESS,
	input  logic [gfx_pkg::INS_W-1:0]   DATA_IN,
	input  logic                        WR,

	input  logic                        V_tick,
	input  logic                        H_tick,

	input  logic [gfx_pkg::COORD_W-1:0] display_x,
	input  logic [gfx_pkg::COORD_W-1:0] display_y,

	// palette write port, single clock pulses
	output logic [gfx_pkg::ADDR_W-1:0]  COPPER_ADDRESS,
	output logic                        COPPER_WR,
	output logic [gfx_pkg::INS_W-1:0]   COPPER_DATA_OUT,

	output logic [gfx_pkg::COLOR_W-1:0] background_color,

	// coordinates after pan and flip
	output logic [gfx_pkg::COORD_W-1:0] display_x_out,
	output logic [gfx_pkg::COORD_W-1:0] display_y_out
);

	typedef enum logic [1:0] {
		S_EXECUTE,
		S_WAIT_LINE,
		S_WRITE_DATA,
		S_HALT
	} c_state_t;

	c_state_t c_state_r, c_state_next;

	logic [gfx_pkg::LIST_AW-1:0] pc_r, pc_next;
	logic [gfx_pkg::INS_W-1:0]   ins;          // word at pc_r
	logic [3:0]                  opcode;
	logic [gfx_pkg::ADDR_W-1:0]  operand;
	logic [gfx_pkg::ADDR_W-1:0]  line_now;     // display_y widened to operand size
	logic [gfx_pkg::ADDR_W-1:0]  wait_y_r, wait_y_next;
	logic [gfx_pkg::ADDR_W-1:0]  wr_addr_r, wr_addr_next;
	logic                        bg_wr;
	logic                        list_wr;

	logic [gfx_pkg::COLOR_W-1:0] bg_r;
	logic [gfx_pkg::COORD_W-1:0] x_pan_r;
	logic                        y_flip_r;

	assign opcode   = ins[gfx_pkg::INS_W-1 -: 4];
	assign operand  = ins[gfx_pkg::ADDR_W-1:0];
	assign line_now = {{(gfx_pkg::ADDR_W - gfx_pkg::COORD_W){1'b0}}, display_y};

	// list memory, read address is next pc so ins lines up with pc_r
	bram #(
		.BITS         (gfx_pkg::INS_W),
		.ADDRESS_BITS (gfx_pkg::LIST_AW)
	) coplist0 (
		.CLK     (CLK),
		.rd_addr (pc_next),
		.rd_data (ins),
		.wr_addr (ADDRESS[gfx_pkg::LIST_AW-1:0]),
		.wr_data (DATA_IN),
		.wr      (list_wr)
	);

	assign list_wr = WR &&
		(ADDRESS[gfx_pkg::ADDR_W-1:gfx_pkg::LIST_AW] == gfx_pkg::ADDR_LIST_SEL);

	// sequencer
	always_comb begin
		c_state_next = c_state_r;
		pc_next      = pc_r;
		wait_y_next  = wait_y_r;
		wr_addr_next = wr_addr_r;
		bg_wr        = 1'b0;

		if (!RSTb || V_tick) begin // restart list at frame start
			c_state_next = S_EXECUTE;
			pc_next      = '0;
		end else begin
			case (c_state_r)
				S_EXECUTE: begin
					case (opcode)
						gfx_pkg::OP_NOP:
							pc_next = pc_r + 1'b1;
						gfx_pkg::OP_WAIT_Y: begin
							if (line_now >= operand) begin
								pc_next = pc_r + 1'b1; // line already reached
							end else begin
								wait_y_next  = operand;
								c_state_next = S_WAIT_LINE;
							end
						end
						gfx_pkg::OP_WRITE: begin
							wr_addr_next = operand;
							pc_next      = pc_r + 1'b1; // data word follows
							c_state_next = S_WRITE_DATA;
						end
						gfx_pkg::OP_JUMP:
							pc_next = operand[gfx_pkg::LIST_AW-1:0];
						gfx_pkg::OP_SET_BG: begin
							bg_wr        = 1'b1;
							wait_y_next  = line_now + 1'b1; // one colour per line
							c_state_next = S_WAIT_LINE;
						end
						gfx_pkg::OP_HALT:
							c_state_next = S_HALT;
						default:
							pc_next = pc_r + 1'b1;
					endcase
				end
				S_WAIT_LINE: begin
					if (line_now >= wait_y_r) begin
						c_state_next = S_EXECUTE;
						pc_next      = pc_r + 1'b1;
					end
				end
				S_WRITE_DATA: begin
					c_state_next = S_EXECUTE;
					pc_next      = pc_r + 1'b1;
				end
				default: ; // halted until frame start
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			c_state_r <= S_EXECUTE;
			pc_r      <= '0;
		end else begin
			c_state_r <= c_state_next;
			pc_r      <= pc_next;
		end
	end

	// wait line and write target
	always_ff @(posedge CLK) begin
		wait_y_r  <= wait_y_next;
		wr_addr_r <= wr_addr_next;
	end

	// copper registers, list colour wins over host
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			bg_r     <= gfx_pkg::BG_RESET;
			x_pan_r  <= '0;
			y_flip_r <= 1'b0;
		end else begin
			if (WR && ADDRESS == gfx_pkg::ADDR_XPAN)
				x_pan_r <= DATA_IN[gfx_pkg::COORD_W-1:0];
			if (WR && ADDRESS == gfx_pkg::ADDR_YFLIP)
				y_flip_r <= DATA_IN[0];
			if (WR && ADDRESS == gfx_pkg::ADDR_BG)
				bg_r <= DATA_IN[gfx_pkg::COLOR_W-1:0];
			if (bg_wr)
				bg_r <= operand[gfx_pkg::COLOR_W-1:0];
		end
	end

	assign background_color = bg_r;

	// second clock of WRITE
	assign COPPER_WR       = (c_state_r == S_WRITE_DATA);
	assign COPPER_ADDRESS  = wr_addr_r;
	assign COPPER_DATA_OUT = ins;

	assign display_x_out = display_x + x_pan_r; // wraps mod 1024
	assign display_y_out = y_flip_r ?
		gfx_pkg::COORD_W'(gfx_pkg::V_ACTIVE - 1) - display_y : display_y;

	// palette pulse only right after a WRITE opcode
	a_wr_in_write_data: assert property (@(posedge CLK) disable iff (!RSTb)
		COPPER_WR |-> (c_state_r == S_WRITE_DATA) && ($past(opcode) == gfx_pkg::OP_WRITE));

	// a pending wait is dropped at frame start
	a_wait_ends_at_frame: assert property (@(posedge CLK) disable iff (!RSTb)
		V_tick |=> c_state_r != S_WAIT_LINE);

	// a wait only ends on the first clock of a new line
	a_wait_ends_at_line: assert property (@(posedge CLK) disable iff (!RSTb)
		(c_state_r == S_WAIT_LINE) && !$past(H_tick) |=> c_state_r == S_WAIT_LINE);

endmodule

// File: hdl/palette_layer.sv
// 16 entry palette with host and copper write ports, copper first.
// turns the panned x coordinate into one registered 12-bit pixel per clock
`timescale 1ns/1ns

module palette_layer (
	input  logic                        CLK,
	input  logic                        RSTb,

	input  logic [gfx_pkg::ADDR_W-1:0]  ADDRESS,
	input  logic [gfx_pkg::INS_W-1:0]   DATA_IN,
	input  logic                        WR,

	input  logic [gfx_pkg::ADDR_W-1:0]  COPPER_ADDRESS,
	input  logic [gfx_pkg::INS_W-1:0]   COPPER_DATA_OUT,
	input  logic                        COPPER_WR,

	input  logic [gfx_pkg::COLOR_W-1:0] background_color,
	input  logic [gfx_pkg::COORD_W-1:0] display_x,
	input  logic [gfx_pkg::COORD_W-1:0] display_y,
	input  logic [gfx_pkg::COORD_W-1:0] display_x_out,

	output logic [gfx_pkg::COLOR_W-1:0] rgb
);

	logic [gfx_pkg::COLOR_W-1:0] palette [16];
	logic [gfx_pkg::COLOR_W-1:0] entry;
	logic                        host_hit;
	logic                        cop_hit;
	logic                        visible;

	// palette window 0xd00..0xd0f
	assign host_hit = WR &&
		(ADDRESS[gfx_pkg::ADDR_W-1:4] == gfx_pkg::ADDR_PAL_BASE[gfx_pkg::ADDR_W-1:4]);
	assign cop_hit  = COPPER_WR &&
		(COPPER_ADDRESS[gfx_pkg::ADDR_W-1:4] == gfx_pkg::ADDR_PAL_BASE[gfx_pkg::ADDR_W-1:4]);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			for (int i = 0; i < 16; i++)
				palette[i] <= '0;
		end else begin
			if (host_hit)
				palette[ADDRESS[3:0]] <= DATA_IN[gfx_pkg::COLOR_W-1:0];
			if (cop_hit) // later assignment, copper wins a clash
				palette[COPPER_ADDRESS[3:0]] <= COPPER_DATA_OUT[gfx_pkg::COLOR_W-1:0];
		end
	end

	// raw coordinates decide visibility, panned x picks the entry
	assign visible = (display_x < gfx_pkg::H_ACTIVE) && (display_y < gfx_pkg::V_ACTIVE);
	assign entry   = palette[display_x_out[3:0]];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			rgb <= '0;
		end else if (!visible) begin
			rgb <= '0; // blanking
		end else if (entry == '0) begin
			rgb <= background_color; // entry 0 is transparent
		end else begin
			rgb <= entry;
		end
	end

	// blank one clock after leaving the visible area
	a_blank_outside: assert property (@(posedge CLK) disable iff (!RSTb)
		!$past(visible) |-> rgb == '0);

endmodule

// File: hdl/gfx_core.sv
// graphics core top: raster timing, copper and palette stage.
// host writes list, palette and copper registers over ADDRESS / DATA_IN / WR
`timescale 1ns/1ns

module gfx_core (
	input  logic                        CLK,
	input  logic                        RSTb,

	input  logic [gfx_pkg::ADDR_W-1:0]  ADDRESS,
	input  logic [gfx_pkg::INS_W-1:0]   DATA_IN,
	input  logic                        WR,

	output logic [gfx_pkg::COLOR_W-1:0] rgb,
	output logic [gfx_pkg::COORD_W-1:0] display_x,
	output logic [gfx_pkg::COORD_W-1:0] display_y,
	output logic [gfx_pkg::COORD_W-1:0] display_x_out,
	output logic [gfx_pkg::COORD_W-1:0] display_y_out,
	output logic                        H_tick,
	output logic                        V_tick
);

	// copper to palette
	logic [gfx_pkg::ADDR_W-1:0]  copper_address;
	logic [gfx_pkg::INS_W-1:0]   copper_data;
	logic                        copper_wr;
	logic [gfx_pkg::COLOR_W-1:0] background_color;

	video_timing u_timing (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.display_x (display_x),
		.display_y (display_y),
		.H_tick    (H_tick),
		.V_tick    (V_tick)
	);

	copper u_copper (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.ADDRESS          (ADDRESS),
		.DATA_IN          (DATA_IN),
		.WR               (WR),
		.V_tick           (V_tick),
		.H_tick           (H_tick),
		.display_x        (display_x),
		.display_y        (display_y),
		.COPPER_ADDRESS   (copper_address),
		.COPPER_WR        (copper_wr),
		.COPPER_DATA_OUT  (copper_data),
		.background_color (background_color),
		.display_x_out    (display_x_out),
		.display_y_out    (display_y_out)
	);

	palette_layer u_palette (
		.CLK              (CLK),
		.RSTb             (RSTb),
		.ADDRESS          (ADDRESS),
		.DATA_IN          (DATA_IN),
		.WR               (WR),
		.COPPER_ADDRESS   (copper_address),
		.COPPER_DATA_OUT  (copper_data),
		.COPPER_WR        (copper_wr),
		.background_color (background_color),
		.display_x        (display_x),
		.display_y        (display_y),
		.display_x_out    (display_x_out),
		.rgb              (rgb)
	);

endmodule

// File: dv/gfx_core_tb.sv
// self-checking testbench for the graphics core. builds a table of host writes,
// pixel waits and expected outputs from a reference model, then replays it
`timescale 1ns/1ns

module gfx_core_tb;

	localparam int K_WRITE    = 0;
	localparam int K_WAIT     = 1;
	localparam int K_RGB      = 2;
	localparam int K_XOUT     = 3;
	localparam int K_YOUT     = 4;
	localparam int K_TICK     = 5;
	localparam int MAX_STEPS  = 512;
	localparam int WAIT_LIMIT = 2 * gfx_pkg::H_TOTAL * gfx_pkg::V_TOTAL; // two frames
	localparam int LIST       = 'h400;
	localparam int PAL        = gfx_pkg::ADDR_PAL_BASE;

	logic                        CLK;
	logic                        RSTb;
	logic [gfx_pkg::ADDR_W-1:0]  ADDRESS;
	logic [gfx_pkg::INS_W-1:0]   DATA_IN;
	logic                        WR;
	logic [gfx_pkg::COLOR_W-1:0] rgb;
	logic [gfx_pkg::COORD_W-1:0] display_x;
	logic [gfx_pkg::COORD_W-1:0] display_y;
	logic [gfx_pkg::COORD_W-1:0] display_x_out;
	logic [gfx_pkg::COORD_W-1:0] display_y_out;
	logic                        H_tick;
	logic                        V_tick;

	gfx_core u_dut (
		.CLK           (CLK),
		.RSTb          (RSTb),
		.ADDRESS       (ADDRESS),
		.DATA_IN       (DATA_IN),
		.WR            (WR),
		.rgb           (rgb),
		.display_x     (display_x),
		.display_y     (display_y),
		.display_x_out (display_x_out),
		.display_y_out (display_y_out),
		.H_tick        (H_tick),
		.V_tick        (V_tick)
	);

	// step table
	int    step_kind [MAX_STEPS];
	int    step_test [MAX_STEPS];
	int    step_a    [MAX_STEPS]; // address, line or expected value
	int    step_b    [MAX_STEPS]; // data or pixel
	int    n_steps;
	int    cur_test;
	string test_name [7];

	// reference model of palette and copper registers
	int model_pal [16];
	int model_bg;
	int model_pan;
	int model_flip;

	int unsigned lcg_state = 74;
	int checks;
	int errors;
	int test_errors;
	int last_x;
	int last_y;

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	function automatic int lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state >> 16);
	endfunction

	function automatic int random_color();
		int c;
		c = lcg_next() & 'hfff;
		if (c == 0)
			c = 1; // zero entries are placed on purpose only
		return c;
	endfunction

	// pixel rule on raw coordinates
	function automatic int pixel_model(input int x, input int y);
		int idx;
		if (x >= gfx_pkg::H_ACTIVE || y >= gfx_pkg::V_ACTIVE)
			return 0;
		idx = (x + model_pan) & 15;
		return (model_pal[idx] == 0) ? model_bg : model_pal[idx];
	endfunction

	// end of line in bit 1, frame origin in bit 0
	function automatic int tick_model(input int x, input int y);
		int h;
		int v;
		h = (x == gfx_pkg::H_TOTAL - 1);
		v = (x == 0 && y == 0);
		return h * 2 + v;
	endfunction

	function automatic void add_step(input int kind, input int a, input int b);
		step_kind[n_steps] = kind;
		step_test[n_steps] = cur_test;
		step_a[n_steps]    = a;
		step_b[n_steps]    = b;
		n_steps++;
	endfunction

	function automatic void add_write(input int addr, input int data);
		add_step(K_WRITE, addr, data);
		if ((addr >> 4) == (PAL >> 4))
			model_pal[addr & 15] = data & 'hfff;
		else if (addr == gfx_pkg::ADDR_XPAN)
			model_pan = data & 'h3ff;
		else if (addr == gfx_pkg::ADDR_YFLIP)
			model_flip = data & 1;
		else if (addr == gfx_pkg::ADDR_BG)
			model_bg = data & 'hfff;
	endfunction

	function automatic void add_pixel(input int y, input int x);
		add_step(K_WAIT, y, x);
		add_step(K_TICK, tick_model(x, y), 0);
		add_step(K_RGB, pixel_model(x, y), 0);
	endfunction

	function automatic void add_coords(input int y, input int x);
		add_step(K_WAIT, y, x);
		add_step(K_TICK, tick_model(x, y), 0);
		add_step(K_XOUT, (x + model_pan) % 1024, 0);
		add_step(K_YOUT, model_flip ? (gfx_pkg::V_ACTIVE - 1 - y) & 'h3ff : y, 0);
		add_step(K_RGB, pixel_model(x, y), 0);
	endfunction

	function automatic void build_table();
		int i;
		int c;
		int old_c;
		int new_c;
		int ca;
		int cb;
		int cskip;
		int colors [16];
		test_name[1] = "reset colours and blanking";
		test_name[2] = "host palette over a line";
		test_name[3] = "copper background per line";
		test_name[4] = "copper wait and palette write";
		test_name[5] = "copper jump and halt";
		test_name[6] = "x pan and y flip";
		n_steps    = 0;
		model_bg   = gfx_pkg::BG_RESET;
		model_pan  = 0;
		model_flip = 0;
		for (i = 0; i < 16; i++)
			model_pal[i] = 0;

		cur_test = 1;
		add_pixel(0, 0);
		add_pixel(2, 22);
		add_pixel(2, 23);
		add_pixel(2, 24); // first blank pixel
		add_pixel(17, 3);

		cur_test = 2;
		add_write(LIST, 'hf000); // park the copper
		for (i = 0; i < 16; i++) begin
			c = (i == 0 || i == 5 || i == 11) ? 0 : random_color();
			add_write(PAL + i, c);
		end
		for (i = 0; i < gfx_pkg::H_TOTAL; i++)
			add_pixel(4, i);

		// entries 5 and 11 are zero, so pixels 11 and 21 show the background
		cur_test = 3;
		add_step(K_WAIT, 17, 0);
		for (i = 0; i < 16; i++) begin
			colors[i] = random_color();
			add_write(LIST + i, 'h7000 | colors[i]);
		end
		add_write(LIST + 16, 'hf000);
		for (i = 0; i < 16; i++) begin
			model_bg = colors[i];
			add_pixel(i, 11);
			add_pixel(i, 21);
		end

		cur_test = 4;
		old_c = model_pal[3];
		new_c = random_color();
		if (new_c == old_c)
			new_c = (old_c == 'hfff) ? 1 : old_c + 1;
		add_step(K_WAIT, 17, 0);
		add_write(LIST + 0, 'h1008);        // wait for line 8
		add_write(LIST + 1, 'h2000 | PAL + 3);
		add_write(LIST + 2, new_c);
		add_write(LIST + 3, 'hf000);
		add_pixel(7, 3);
		model_pal[3] = new_c;
		add_pixel(8, 19);
		add_pixel(12, 3);
		add_pixel(2, 3); // next frame, copper value still held
		add_write(PAL + 3, old_c);
		add_pixel(5, 3);
		model_pal[3] = new_c;
		add_pixel(9, 3);

		cur_test = 5;
		ca    = random_color();
		cskip = random_color();
		cb    = random_color();
		add_step(K_WAIT, 17, 0);
		add_write(LIST + 0, 'h7000 | ca);
		add_write(LIST + 1, 'h3003);        // skip the next word
		add_write(LIST + 2, 'h7000 | cskip);
		add_write(LIST + 3, 'h7000 | cb);
		add_write(LIST + 4, 'hf000);
		model_bg = ca;
		add_pixel(0, 11);
		model_bg = cb;
		add_pixel(1, 21);
		add_pixel(5, 11);
		add_pixel(15, 21);

		cur_test = 6;
		add_step(K_WAIT, 17, 0);
		add_write(LIST, 'hf000);
		add_write(gfx_pkg::ADDR_BG, 'h0a5);
		add_write(gfx_pkg::ADDR_XPAN, 5);
		add_write(gfx_pkg::ADDR_YFLIP, 1);
		add_coords(3, 2);
		add_coords(3, 11); // panned onto entry 0
		add_write(gfx_pkg::ADDR_XPAN, 1022);
		add_coords(6, 4);  // wraps to index 2
		add_write(gfx_pkg::ADDR_YFLIP, 0);
		add_write(gfx_pkg::ADDR_XPAN, 0);
		add_coords(10, 20);
	endfunction

	task automatic host_write(input int addr, input int data);
		ADDRESS = addr;
		DATA_IN = data;
		WR      = 1'b1;
		@(negedge CLK);
		WR = 1'b0;
	endtask

	task automatic wait_pixel(input int y, input int x, output bit ok);
		int n;
		n = 0;
		while (!(display_y == y && display_x == x) && n < WAIT_LIMIT) begin
			@(negedge CLK);
			n++;
		end
		ok     = (display_y == y && display_x == x);
		last_y = y;
		last_x = x;
		if (!ok)
			$display("timeout: line %0d pixel %0d not reached within %0d clocks",
				y, x, WAIT_LIMIT);
	endtask

	task automatic check_value(input logic [31:0] got, input int exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			test_errors++;
			$display("ERROR at %0t: %s at line %0d pixel %0d is %h, expected %h",
				$time, what, last_y, last_x, got, exp);
		end
	endtask

	initial begin
		int s;
		bit ok;
		RSTb        = 1'b0;
		WR          = 1'b0;
		ADDRESS     = '0;
		DATA_IN     = '0;
		checks      = 0;
		errors      = 0;
		test_errors = 0;
		ok          = 1'b1;
		build_table();
		repeat (4) @(posedge CLK);
		@(negedge CLK);
		RSTb = 1'b1;

		for (s = 0; s < n_steps && ok; s++) begin
			case (step_kind[s])
				K_WRITE: host_write(step_a[s], step_b[s]);
				K_WAIT:  wait_pixel(step_a[s], step_b[s], ok);
				K_RGB: begin
					@(negedge CLK); // rgb is one clock behind
					check_value(rgb, step_a[s], "rgb");
				end
				K_XOUT:  check_value(display_x_out, step_a[s], "display_x_out");
				K_TICK:  check_value({H_tick, V_tick}, step_a[s], "H_tick/V_tick");
				default: check_value(display_y_out, step_a[s], "display_y_out");
			endcase
			if (!ok) begin
				errors++;
				test_errors++;
			end
			if (s == n_steps - 1 || step_test[s + 1] != step_test[s] || !ok) begin
				$display("test %0d %s: %0d mismatches", step_test[s],
					test_name[step_test[s]], test_errors);
				test_errors = 0;
			end
		end

		$display("%0d checks, %0d failed", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

// File: gfx_core.f
hdl/gfx_pkg.sv
hdl/bram.sv
hdl/video_timing.sv
hdl/copper.sv
hdl/palette_layer.sv
hdl/gfx_core.sv
dv/gfx_core_tb.sv

// File: Bender.yml
package:
  name: gfx_core

sources:
  - hdl/gfx_pkg.sv
  - hdl/bram.sv
  - hdl/video_timing.sv
  - hdl/copper.sv
  - hdl/palette_layer.sv
  - hdl/gfx_core.sv
  - target: test
    files:
      - dv/gfx_core_tb.sv
